// ==== verilog/rvPkg.sv ====
package rvPkg;

	localparam int memWords = 10; // Word index bits, 1024 words

	typedef logic [31:0] addrT; // Byte address
	typedef logic [31:0] dataT; // Register or memory word
	typedef logic [31:0] instrT;
	typedef logic [4:0] regNumT;
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] func3T;
	typedef logic [6:0] func7T;
	typedef logic [memWords-1:0] memAddrT;

	localparam addrT resetPc = 32'h0000_0000; // First fetch address

	// Major opcodes of RV32I
	localparam opcodeT opLoad = 7'b0000011;
	localparam opcodeT opImm = 7'b0010011;
	localparam opcodeT opAuipc = 7'b0010111;
	localparam opcodeT opStore = 7'b0100011;
	localparam opcodeT opReg = 7'b0110011;
	localparam opcodeT opLui = 7'b0110111;
	localparam opcodeT opBranch = 7'b1100011;
	localparam opcodeT opJalr = 7'b1100111;
	localparam opcodeT opJal = 7'b1101111;

endpackage

// ==== verilog/pipeIfs.sv ====
`timescale 1ns/1ps

interface memBus;
	import rvPkg::*;

	logic req;
	logic we;
	addrT addr; // Byte address
	dataT wdata;
	dataT rdata; // Valid in the granted cycle
	logic grant;

	modport requester (output req, we, addr, wdata, input rdata, grant);
	modport arbiter (input req, we, addr, wdata, output rdata, grant);
endinterface

interface decodeBus;
	import rvPkg::*;

	logic valid;
	addrT pc;
	dataT imm;
	opcodeT opcode;
	func3T func3;
	func7T func7;
	regNumT regNum0; // rs1
	regNumT regNum1; // rs2
	regNumT regWriteNum; // rd

	modport source (output valid, pc, imm, opcode, func3, func7, regNum0, regNum1, regWriteNum);
	modport sink (input valid, pc, imm, opcode, func3, func7, regNum0, regNum1, regWriteNum);
endinterface

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic we,
	input rvPkg::regNumT writeNum,
	input rvPkg::dataT writeData,
	input rvPkg::regNumT readNum0,
	input rvPkg::regNumT readNum1,
	output rvPkg::dataT readData0,
	output rvPkg::dataT readData1,
	input rvPkg::regNumT regWatchNum,
	output rvPkg::dataT regWatchData
);
	import rvPkg::*;

	dataT regs [32]; // Entry 0 never written

	always_ff @(posedge clk)
		if (we && writeNum != 5'd0)
			regs[writeNum] <= writeData;

	assign readData0 = (readNum0 == 5'd0) ? '0 : regs[readNum0];
	assign readData1 = (readNum1 == 5'd0) ? '0 : regs[readNum1];
	assign regWatchData = (regWatchNum == 5'd0) ? '0 : regs[regWatchNum]; // Testbench view
endmodule

// ==== verilog/unifiedMem.sv ====
`timescale 1ns/1ps

module unifiedMem (
	input logic clk,
	input logic memWe,
	input rvPkg::memAddrT memAddr,
	input rvPkg::dataT memWdata,
	output rvPkg::dataT memRdata,
	input rvPkg::addrT memWatchAddr,
	output rvPkg::dataT memWatchData
);
	import rvPkg::*;

	dataT mem [1 << memWords]; // Code and data share this array

	always_ff @(posedge clk)
		if (memWe)
			mem[memAddr] <= memWdata;

	assign memRdata = mem[memAddr]; // Combinational read

	// Watch port takes a byte address
	assign memWatchData = mem[memWatchAddr[memWords+1:2]];
endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
	memBus.arbiter loadPort,
	memBus.arbiter dataPort,
	memBus.arbiter fetchPort,
	output logic memWe,
	output rvPkg::memAddrT memAddr,
	output rvPkg::dataT memWdata,
	input rvPkg::dataT memRdata
);
	import rvPkg::*;

	addrT selAddr; // Byte address of the winner

	// Loader first, then data, then fetch
	assign loadPort.grant = loadPort.req;
	assign dataPort.grant = dataPort.req && !loadPort.req;
	assign fetchPort.grant = fetchPort.req && !loadPort.req && !dataPort.req;

	always_comb
	begin
		if (loadPort.req)
		begin
			memWe = loadPort.we;
			selAddr = loadPort.addr;
			memWdata = loadPort.wdata;
		end
		else if (dataPort.req)
		begin
			memWe = dataPort.we;
			selAddr = dataPort.addr;
			memWdata = dataPort.wdata;
		end
		else
		begin
			memWe = fetchPort.req && fetchPort.we; // No write when idle
			selAddr = fetchPort.addr;
			memWdata = fetchPort.wdata;
		end
	end

	assign memAddr = selAddr[memWords+1:2]; // Byte to word index

	assign loadPort.rdata = memRdata;
	assign dataPort.rdata = memRdata;
	assign fetchPort.rdata = memRdata;
endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
	input logic clk,
	input logic rst,
	memBus.requester fetchPort,
	input logic pcWriteEnable,
	input rvPkg::addrT pcWriteData,
	output logic instrValid,
	output rvPkg::instrT instr,
	output rvPkg::addrT instrPc,
	output rvPkg::addrT pc
);
	import rvPkg::*;

	assign fetchPort.req = !rst; // Fetch every cycle outside reset
	assign fetchPort.we = 1'b0;
	assign fetchPort.addr = pc;
	assign fetchPort.wdata = '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= resetPc;
			instrValid <= 1'b0;
		end
		else if (pcWriteEnable)
		begin
			pc <= pcWriteData; // Redirect drops the captured word
			instrValid <= 1'b0;
		end
		else if (fetchPort.grant)
		begin
			pc <= pc + 32'd4;
			instrValid <= 1'b1;
		end
		else
			instrValid <= 1'b0; // Lost arbitration, bubble
	end

	always_ff @(posedge clk)
	begin
		if (fetchPort.grant)
		begin
			instr <= fetchPort.rdata;
			instrPc <= pc;
		end
	end
endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic instrValid,
	input rvPkg::instrT instr,
	input rvPkg::addrT instrPc,
	decodeBus.source decoded
);
	import rvPkg::*;

	opcodeT opcode;
	dataT immNext;

	assign opcode = instr[6:0];

	// Immediate by instruction format
	always_comb
	begin
		case (opcode)
			opImm:
			begin
				if (instr[13:12] == 2'b01)
					immNext = {20'b0, instr[31:20]}; // slli, srli, srai
				else
					immNext = {{20{instr[31]}}, instr[31:20]};
			end
			opLoad, opJalr:
				immNext = {{20{instr[31]}}, instr[31:20]};
			opStore:
				immNext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			opBranch:
				immNext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opLui, opAuipc:
				immNext = {instr[31:12], 12'b0};
			opJal:
				immNext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				immNext = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			decoded.valid <= 1'b0;
		else
			decoded.valid <= instrValid && !flush; // Flush on taken branch or jump
	end

	always_ff @(posedge clk)
	begin
		decoded.pc <= instrPc;
		decoded.imm <= immNext;
		decoded.opcode <= opcode;
		decoded.func3 <= instr[14:12];
		decoded.func7 <= instr[31:25];
		decoded.regNum0 <= instr[19:15];
		decoded.regNum1 <= instr[24:20];
		decoded.regWriteNum <= instr[11:7];
	end
endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rst,
	decodeBus.sink decoded,
	memBus.requester dataPort,
	output logic pcWriteEnable,
	output rvPkg::addrT pcWriteData,
	input rvPkg::regNumT regWatchNum,
	output rvPkg::dataT regWatchData
);
	import rvPkg::*;

	dataT rs1Data;
	dataT rs2Data;
	dataT aluB;
	dataT aluOut;
	dataT result;
	addrT jalrTarget;
	logic [4:0] shamt;
	logic writes;
	logic taken;

	regFile regs (
		.clk(clk),
		.we(decoded.valid && writes && !rst), // No writeback while in reset
		.writeNum(decoded.regWriteNum),
		.writeData(result),
		.readNum0(decoded.regNum0),
		.readNum1(decoded.regNum1),
		.readData0(rs1Data),
		.readData1(rs2Data),
		.regWatchNum(regWatchNum),
		.regWatchData(regWatchData)
	);

	assign aluB = (decoded.opcode == opReg) ? rs2Data : decoded.imm;
	assign shamt = aluB[4:0];

	always_comb
	begin
		case (decoded.func3)
			3'b000:
			begin
				if (decoded.opcode == opReg && decoded.func7[5])
					aluOut = rs1Data - aluB;
				else
					aluOut = rs1Data + aluB;
			end
			3'b001: aluOut = rs1Data << shamt;
			3'b010: aluOut = dataT'($signed(rs1Data) < $signed(aluB));
			3'b011: aluOut = dataT'(rs1Data < aluB);
			3'b100: aluOut = rs1Data ^ aluB;
			3'b101:
			begin
				if (decoded.func7[5])
					aluOut = $signed(rs1Data) >>> shamt; // Arithmetic shift
				else
					aluOut = rs1Data >> shamt;
			end
			3'b110: aluOut = rs1Data | aluB;
			default: aluOut = rs1Data & aluB;
		endcase
	end

	// Branch conditions
	always_comb
	begin
		case (decoded.func3)
			3'b000: taken = rs1Data == rs2Data;
			3'b001: taken = rs1Data != rs2Data;
			3'b100: taken = $signed(rs1Data) < $signed(rs2Data);
			3'b101: taken = $signed(rs1Data) >= $signed(rs2Data);
			3'b110: taken = rs1Data < rs2Data;
			3'b111: taken = rs1Data >= rs2Data;
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		writes = 1'b1;
		case (decoded.opcode)
			opImm, opReg: result = aluOut;
			opLoad: result = dataPort.rdata;
			opJal, opJalr: result = decoded.pc + 32'd4; // Link value
			opLui: result = decoded.imm;
			opAuipc: result = decoded.pc + decoded.imm;
			default:
			begin
				result = aluOut;
				writes = 1'b0; // Stores and branches
			end
		endcase
	end

	// Word loads and stores, one execute cycle
	assign dataPort.req = decoded.valid && (decoded.opcode == opLoad || decoded.opcode == opStore);
	assign dataPort.we = decoded.opcode == opStore;
	assign dataPort.addr = rs1Data + decoded.imm;
	assign dataPort.wdata = rs2Data;

	assign jalrTarget = rs1Data + decoded.imm;
	assign pcWriteEnable = decoded.valid && (decoded.opcode == opJal || decoded.opcode == opJalr
		|| (decoded.opcode == opBranch && taken));
	assign pcWriteData = (decoded.opcode == opJalr) ? {jalrTarget[31:1], 1'b0}
		: decoded.pc + decoded.imm;
endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic rst,
	input logic loadEnable,
	input rvPkg::addrT loadAddr,
	input rvPkg::dataT loadData,
	input rvPkg::regNumT regWatchNum,
	output rvPkg::dataT regWatchData,
	input rvPkg::addrT memWatchAddr,
	output rvPkg::dataT memWatchData,
	output rvPkg::addrT pc
);
	import rvPkg::*;

	logic instrValid;
	instrT instr;
	addrT instrPc;
	logic pcWriteEnable;
	addrT pcWriteData;
	logic memWe;
	memAddrT memAddr;
	dataT memWdata;
	dataT memRdata;

	memBus loadPort ();
	memBus dataPort ();
	memBus fetchPort ();
	decodeBus decoded ();

	// Program loader, write only
	assign loadPort.req = loadEnable;
	assign loadPort.we = 1'b1;
	assign loadPort.addr = loadAddr;
	assign loadPort.wdata = loadData;

	fetchUnit fetch (
		.clk(clk),
		.rst(rst),
		.fetchPort(fetchPort),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.instrValid(instrValid),
		.instr(instr),
		.instrPc(instrPc),
		.pc(pc)
	);

	decodeStage decode (
		.clk(clk),
		.rst(rst),
		.flush(pcWriteEnable),
		.instrValid(instrValid),
		.instr(instr),
		.instrPc(instrPc),
		.decoded(decoded)
	);

	executeStage execute (
		.clk(clk),
		.rst(rst),
		.decoded(decoded),
		.dataPort(dataPort),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.regWatchNum(regWatchNum),
		.regWatchData(regWatchData)
	);

	memArbiter arbiter (
		.loadPort(loadPort),
		.dataPort(dataPort),
		.fetchPort(fetchPort),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata)
	);

	unifiedMem memory (
		.clk(clk),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata),
		.memWatchAddr(memWatchAddr),
		.memWatchData(memWatchData)
	);
endmodule

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	import rvPkg::*;

	localparam int numTests = 5;
	localparam int clkPeriod = 10;
	localparam int cyclesPerTest = 200;

	logic clk = 1'b0;
	logic rst;
	logic loadEnable;
	addrT loadAddr;
	dataT loadData;
	regNumT regWatchNum;
	dataT regWatchData;
	addrT memWatchAddr;
	dataT memWatchData;
	addrT pc;

	instrT prog[$]; // Program being built by the current test
	addrT haltAddr; // Address of the closing jump to self
	int errors = 0;
	int checks = 0;
	integer seed = 73047;

	cpuTop UUT (
		.clk(clk),
		.rst(rst),
		.loadEnable(loadEnable),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.regWatchNum(regWatchNum),
		.regWatchData(regWatchData),
		.memWatchAddr(memWatchAddr),
		.memWatchData(memWatchData),
		.pc(pc)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic instrT iFormat(opcodeT op, regNumT rd, func3T f3, regNumT rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instrT rFormat(func7T f7, regNumT rs2, regNumT rs1, func3T f3,
		regNumT rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic instrT sFormat(regNumT rs2, regNumT rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore}; // sw only
	endfunction

	function automatic instrT bFormat(func3T f3, regNumT rs1, regNumT rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	function automatic instrT uFormat(opcodeT op, regNumT rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic instrT jFormat(regNumT rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	task automatic checkValue(input string name, input dataT actual, input dataT expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkReg(input regNumT num, input dataT expected);
		@(posedge clk);
		#1;
		regWatchNum = num;
		#1;
		checkValue($sformatf("x%0d", num), regWatchData, expected);
	endtask

	task automatic checkMem(input addrT addr, input dataT expected);
		@(posedge clk);
		#1;
		memWatchAddr = addr;
		#1;
		checkValue($sformatf("mem[%h]", addr), memWatchData, expected);
	endtask

	// Writes prog through the loader port while the core sits in reset
	task automatic loadProgram();
		int i;
		haltAddr = prog.size() * 4;
		prog.push_back(jFormat(5'd0, 21'd0)); // Jump to self
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (i = 0; i < prog.size(); i++)
		begin
			loadEnable = 1'b1;
			loadAddr = i * 4;
			loadData = prog[i];
			@(posedge clk);
			#1;
		end
		loadEnable = 1'b0;
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic runUntilHalt();
		int passes;
		passes = 0;
		rst = 1'b0;
		// Jump to self revisits the halt address every third cycle
		while (passes < 4)
		begin
			@(posedge clk);
			#1;
			if (pc == haltAddr)
				passes++;
		end
		// Two fetches behind the jump, then its redirect
		@(posedge clk);
		#1;
		checkValue("pc", pc, haltAddr + 32'd4);
		@(posedge clk);
		#1;
		checkValue("pc", pc, haltAddr + 32'd8);
		@(posedge clk);
		#1;
		checkValue("pc", pc, haltAddr);
	endtask

	task automatic testAlu();
		dataT a;
		dataT b;
		a = 32'hFFFF_FF9C; // -100
		b = 32'h0000_05A7;
		prog.delete();
		prog.push_back(iFormat(opImm, 5'd1, 3'b000, 5'd0, 12'hF9C));
		prog.push_back(iFormat(opImm, 5'd2, 3'b000, 5'd0, 12'h5A7));
		prog.push_back(iFormat(opImm, 5'd3, 3'b001, 5'd1, 12'h004)); // slli by 4
		prog.push_back(iFormat(opImm, 5'd4, 3'b101, 5'd1, 12'h403)); // srai by 3
		prog.push_back(iFormat(opImm, 5'd5, 3'b011, 5'd2, 12'hFFF)); // sltiu against all ones
		prog.push_back(rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));
		prog.push_back(rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd7));
		prog.push_back(rFormat(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
		prog.push_back(rFormat(7'h00, 5'd2, 5'd1, 3'b110, 5'd9));
		prog.push_back(rFormat(7'h00, 5'd2, 5'd1, 3'b111, 5'd10));
		prog.push_back(iFormat(opImm, 5'd11, 3'b000, 5'd0, 12'h007));
		prog.push_back(rFormat(7'h00, 5'd11, 5'd2, 3'b001, 5'd12));
		prog.push_back(rFormat(7'h00, 5'd11, 5'd1, 3'b101, 5'd13));
		prog.push_back(rFormat(7'h20, 5'd11, 5'd1, 3'b101, 5'd14));
		prog.push_back(iFormat(opImm, 5'd0, 3'b000, 5'd1, 12'h037)); // Writes to x0
		prog.push_back(rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
		prog.push_back(rFormat(7'h00, 5'd2, 5'd0, 3'b000, 5'd15)); // x0 as a source
		loadProgram();
		runUntilHalt();
		checkReg(5'd1, a);
		checkReg(5'd2, b);
		checkReg(5'd3, a << 4);
		checkReg(5'd4, dataT'($signed(a) >>> 3));
		checkReg(5'd5, 32'd1);
		checkReg(5'd6, a + b);
		checkReg(5'd7, a - b);
		checkReg(5'd8, a ^ b);
		checkReg(5'd9, a | b);
		checkReg(5'd10, a & b);
		checkReg(5'd12, b << 7);
		checkReg(5'd13, a >> 7);
		checkReg(5'd14, dataT'($signed(a) >>> 7));
		checkReg(5'd0, 32'd0);
		checkReg(5'd15, b);
	endtask

	task automatic testLoadStore();
		dataT w0;
		dataT w1;
		dataT w2;
		instrT image[$];
		int i;
		w0 = 32'h0000_0123;
		w1 = 32'hABCD_E456;
		w2 = 32'hFFFF_FFFF;
		prog.delete();
		prog.push_back(iFormat(opImm, 5'd1, 3'b000, 5'd0, 12'h600)); // Data base
		prog.push_back(iFormat(opImm, 5'd2, 3'b000, 5'd0, 12'h123));
		prog.push_back(uFormat(opLui, 5'd3, 20'hABCDE));
		prog.push_back(iFormat(opImm, 5'd3, 3'b000, 5'd3, 12'h456));
		prog.push_back(iFormat(opImm, 5'd4, 3'b000, 5'd0, 12'hFFF));
		prog.push_back(sFormat(5'd2, 5'd1, 12'h000));
		prog.push_back(sFormat(5'd3, 5'd1, 12'h004));
		prog.push_back(sFormat(5'd4, 5'd1, 12'h00C));
		prog.push_back(sFormat(5'd3, 5'd1, 12'hFF8)); // Negative offset
		prog.push_back(iFormat(opLoad, 5'd5, 3'b010, 5'd1, 12'h000));
		prog.push_back(iFormat(opLoad, 5'd6, 3'b010, 5'd1, 12'h004));
		prog.push_back(iFormat(opLoad, 5'd7, 3'b010, 5'd1, 12'h00C));
		prog.push_back(iFormat(opLoad, 5'd8, 3'b010, 5'd1, 12'hFF8));
		prog.push_back(rFormat(7'h00, 5'd7, 5'd8, 3'b000, 5'd9)); // Uses the load at once
		loadProgram();
		image = prog;
		runUntilHalt();
		checkMem(32'h600, w0);
		checkMem(32'h604, w1);
		checkMem(32'h60C, w2);
		checkMem(32'h5F8, w1);
		checkReg(5'd5, w0);
		checkReg(5'd6, w1);
		checkReg(5'd7, w2);
		checkReg(5'd8, w1);
		checkReg(5'd9, w1 + w2);
		for (i = 0; i < image.size(); i++)
			checkMem(i * 4, image[i]);
	endtask

	task automatic testBranches();
		func3T conds[6];
		regNumT takenA[6];
		regNumT takenB[6];
		regNumT notA[6];
		regNumT notB[6];
		logic [11:0] flag;
		int i;
		// beq, bne, blt, bge, bltu, bgeu with x1 = -3 and x2 = x3 = 5
		conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		takenA = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
		takenB = '{5'd3, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
		notA = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
		notB = '{5'd2, 5'd3, 5'd1, 5'd2, 5'd2, 5'd1};
		prog.delete();
		prog.push_back(iFormat(opImm, 5'd1, 3'b000, 5'd0, 12'hFFD));
		prog.push_back(iFormat(opImm, 5'd2, 3'b000, 5'd0, 12'h005));
		prog.push_back(iFormat(opImm, 5'd3, 3'b000, 5'd0, 12'h005));
		prog.push_back(iFormat(opImm, 5'd29, 3'b000, 5'd0, 12'h000));
		prog.push_back(iFormat(opImm, 5'd30, 3'b000, 5'd0, 12'h000));
		prog.push_back(iFormat(opImm, 5'd31, 3'b000, 5'd0, 12'h000));
		for (i = 0; i < 6; i++)
		begin
			flag = 12'd1 << i;
			prog.push_back(bFormat(conds[i], takenA[i], takenB[i], 13'd12));
			prog.push_back(iFormat(opImm, 5'd30, 3'b110, 5'd30, flag)); // Shadow slots
			prog.push_back(iFormat(opImm, 5'd30, 3'b110, 5'd30, flag));
			prog.push_back(iFormat(opImm, 5'd31, 3'b110, 5'd31, flag)); // Branch target
			prog.push_back(bFormat(conds[i], notA[i], notB[i], 13'd8));
			prog.push_back(iFormat(opImm, 5'd29, 3'b110, 5'd29, flag)); // Fall through
		end
		loadProgram();
		runUntilHalt();
		checkReg(5'd30, 32'h0000_0000);
		checkReg(5'd31, 32'h0000_003F);
		checkReg(5'd29, 32'h0000_003F);
	endtask

	task automatic testJumps();
		addrT auipcAddr0;
		addrT auipcAddr1;
		addrT jalAddr;
		addrT jalrAddr;
		addrT jalrBase;
		prog.delete();
		prog.push_back(iFormat(opImm, 5'd6, 3'b000, 5'd0, 12'h000));
		prog.push_back(iFormat(opImm, 5'd10, 3'b000, 5'd0, 12'h000));
		prog.push_back(iFormat(opImm, 5'd11, 3'b000, 5'd0, 12'h000));
		prog.push_back(uFormat(opLui, 5'd1, 20'h12345));
		auipcAddr0 = prog.size() * 4;
		prog.push_back(uFormat(opAuipc, 5'd2, 20'h00010));
		jalAddr = prog.size() * 4;
		prog.push_back(jFormat(5'd3, 21'd12));
		prog.push_back(iFormat(opImm, 5'd10, 3'b000, 5'd10, 12'h001));
		prog.push_back(iFormat(opImm, 5'd10, 3'b000, 5'd10, 12'h001));
		jalrAddr = prog.size() * 4 + 4;
		jalrBase = jalrAddr + 9; // Odd, plus 4 lands one past the target
		prog.push_back(iFormat(opImm, 5'd4, 3'b000, 5'd0, jalrBase[11:0]));
		prog.push_back(iFormat(opJalr, 5'd5, 3'b000, 5'd4, 12'h004));
		prog.push_back(iFormat(opImm, 5'd11, 3'b000, 5'd11, 12'h001));
		prog.push_back(iFormat(opImm, 5'd11, 3'b000, 5'd11, 12'h001));
		prog.push_back(iFormat(opImm, 5'd6, 3'b000, 5'd0, 12'h001)); // jalr target
		auipcAddr1 = prog.size() * 4;
		prog.push_back(uFormat(opAuipc, 5'd7, 20'hFFFFF));
		loadProgram();
		runUntilHalt();
		checkReg(5'd1, 32'h1234_5000);
		checkReg(5'd2, auipcAddr0 + 32'h0001_0000);
		checkReg(5'd3, jalAddr + 32'd4);
		checkReg(5'd4, jalrBase);
		checkReg(5'd5, jalrAddr + 32'd4);
		checkReg(5'd6, 32'd1);
		checkReg(5'd7, auipcAddr1 + 32'hFFFF_F000);
		checkReg(5'd10, 32'd0);
		checkReg(5'd11, 32'd0);
	endtask

	task automatic testRandomImm();
		dataT model;
		dataT rnd;
		dataT ext;
		logic [11:0] imm;
		int i;
		model = '0;
		prog.delete();
		prog.push_back(iFormat(opImm, 5'd1, 3'b000, 5'd0, 12'h000));
		for (i = 0; i < 20; i++)
		begin
			rnd = $random(seed);
			imm = rnd[11:0];
			ext = {{20{imm[11]}}, imm}; // I format sign extension
			if (rnd[12])
			begin
				prog.push_back(iFormat(opImm, 5'd1, 3'b100, 5'd1, imm));
				model = model ^ ext;
			end
			else
			begin
				prog.push_back(iFormat(opImm, 5'd1, 3'b000, 5'd1, imm));
				model = model + ext;
			end
		end
		loadProgram();
		runUntilHalt();
		checkReg(5'd1, model);
	endtask

	initial
	begin
		rst = 1'b1;
		loadEnable = 1'b0;
		loadAddr = '0;
		loadData = '0;
		regWatchNum = '0;
		memWatchAddr = '0;
		repeat (4) @(posedge clk);
		#1;
		testAlu();
		testLoadStore();
		testBranches();
		testJumps();
		testRandomImm();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(numTests * cyclesPerTest * clkPeriod);
		$display("Timeout: the tests did not finish within %0d cycles",
			numTests * cyclesPerTest);
		$display("TEST FAILED");
		$finish;
	end
endmodule

// ==== sim.f ====
verilog/rvPkg.sv
verilog/pipeIfs.sv
verilog/regFile.sv
verilog/unifiedMem.sv
verilog/memArbiter.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/cpuTop.sv
verification/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuTb
RTL_TOP ?= cpuTop
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing
LINT_FLAGS ?=

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
